/* Bender.yml */
package:
  name: sh_decode_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/sh_decode_pkg.sv
      - hdl/sh_arith_decoder.sv
      - hdl/sh_move_decoder.sv
      - hdl/sh_branch_decoder.sv
      - hdl/sh_step_sequencer.sv
      - hdl/sh_decode_select.sv
      - hdl/sh_decode_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_sh_decode_unit.sv

/* dv/tb_sh_decode_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sh_decode_params.svh"

module tb_sh_decode_unit import sh_decode_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int N_INSTR = 64;
	localparam int MAX_STEPS = 8;
	localparam int WATCHDOG_CYCLES = N_INSTR * 4 + 32;

	typedef enum int {
		K_ADD,
		K_CMPEQ,
		K_LOAD,
		K_STORE,
		K_BRA,
		K_BSR,
		K_BT,
		K_ILLEGAL
	} instr_kind_e;

	logic                  clk;
	logic                  rst_n;
	logic [`SH_IR_W-1:0]   ir;
	logic                  ir_valid;
	logic                  bc;
	dec_instr_t            deci;
	logic                  deci_valid;
	logic                  illegal;
	logic [`SH_STEP_W-1:0] step;
	logic                  ir_done;

	instr_kind_e           cur_kind;
	logic [31:0]           rng;

	// Context of the cycle that deci reflects
	logic                  p_valid = 1'b0;
	logic                  p_done = 1'b0;
	instr_kind_e           p_kind;
	logic [`SH_IR_W-1:0]   p_ir;
	logic [`SH_STEP_W-1:0] p_step;
	logic                  p_bc;

	sh_decode_unit sh_decode_unit_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.ir         (ir),
		.ir_valid   (ir_valid),
		.bc         (bc),
		.deci       (deci),
		.deci_valid (deci_valid),
		.illegal    (illegal),
		.step       (step),
		.ir_done    (ir_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Branches take a second idle step, BT only when taken
	function automatic logic [`SH_STEP_W-1:0] expected_last(input instr_kind_e k, input logic b);
		case (k)
			K_BRA, K_BSR: return 3'd1;
			K_BT: return {2'b00, b};
			default: return 3'd0;
		endcase
	endfunction

	task automatic check_failed(input string msg);
		$display("Error: %0t ns: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1, "Check failed");
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Run aborted");
	endtask

	task automatic check_decoded();
		logic [`SH_REGN_W-1:0] rn;
		logic [`SH_REGN_W-1:0] rm;
		rn = {1'b0, p_ir[11:8]};
		rm = {1'b0, p_ir[7:4]};
		assert (deci_valid == p_valid) else check_failed("deci_valid does not follow ir_valid");
		if (!p_valid) begin
			assert (deci == DECI_RESET) else check_failed("deci not idle without ir_valid");
			assert (!illegal) else check_failed("illegal set without ir_valid");
		end else begin
			assert (illegal == (p_kind == K_ILLEGAL)) else check_failed("illegal flag wrong");
			assert (deci.lst == expected_last(p_kind, p_bc)) else check_failed("last step wrong");
			case (p_kind)
				K_ADD, K_CMPEQ: begin
					assert (deci.ra.num == rn && deci.ra.re && deci.ra.we == (p_kind == K_ADD))
						else check_failed("port A wrong for register arithmetic");
					assert (deci.rb.num == rm && deci.rb.re && !deci.rb.we)
						else check_failed("port B wrong for register arithmetic");
					assert (deci.alu.op == ALU_ADD) else check_failed("ALU operation not add");
					assert (deci.tw == (p_kind == K_CMPEQ)) else check_failed("T write wrong");
				end
				K_LOAD: begin
					assert (deci.mem.r && !deci.mem.w && deci.mem.sz == 2'b10)
						else check_failed("memory control wrong for long load");
					assert (deci.immt == IMM_ZIMM4) else check_failed("load immediate type wrong");
					assert (deci.ra.num == rn && deci.ra.we) else check_failed("load does not write Rn");
				end
				K_STORE: begin
					assert (deci.mem.w && !deci.mem.r && deci.mem.sz == 2'b00)
						else check_failed("memory control wrong for byte store");
					assert (!deci.ra.we && !deci.rb.we) else check_failed("store writes a register");
				end
				K_BRA, K_BSR: begin
					assert (deci.pcw == (p_step == 3'd0)) else check_failed("branch PC write wrong");
					if (p_step == 3'd0) begin
						assert (deci.br.bi && deci.rb.num == `SH_REG_PR &&
							deci.rb.we == (p_kind == K_BSR))
							else check_failed("branch fields or PR port wrong");
					end
				end
				K_BT: begin
					assert (deci.pcw == (p_bc && p_step == 3'd0)) else check_failed("BT PC write wrong");
					if (p_step == 3'd0) begin
						assert (deci.br.bi) else check_failed("BT branch flag clear");
					end
				end
				default: begin
					assert (deci == DECI_RESET) else check_failed("illegal opcode word not idle");
				end
			endcase
		end
	endtask

	task automatic check_steps();
		if (!p_valid || p_done) begin
			assert (step == 3'd0) else check_failed("step did not restart at 0");
		end else begin
			assert (step == p_step + 3'd1) else check_failed("step did not advance");
		end
		if (ir_valid) begin
			assert (ir_done == (step == expected_last(cur_kind, bc)))
				else check_failed("ir_done does not match the last step");
		end else begin
			assert (!ir_done) else check_failed("ir_done high without ir_valid");
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			p_valid = 1'b0;
			p_done = 1'b0;
		end else begin
			check_decoded();
			check_steps();
			p_valid = ir_valid;
			p_kind = cur_kind;
			p_ir = ir;
			p_step = step;
			p_bc = bc;
			p_done = ir_done;
		end
	end

	// Holds the instruction until ir_done is seen
	task automatic drive_instr(input instr_kind_e k, input logic [15:0] op, input logic b);
		int   cycles;
		logic done_seen;
		ir <= op;
		ir_valid <= 1'b1;
		bc <= b;
		cur_kind <= k;
		cycles = 0;
		done_seen = 1'b0;
		while (!done_seen) begin
			@(posedge clk);
			cycles++;
			done_seen = ir_done;
			if (!done_seen && cycles >= MAX_STEPS) begin
				abort_run("ir_done did not rise while the instruction was held");
			end
		end
	endtask

	initial begin
		instr_kind_e     k;
		logic [15:0]     op;
		logic            b;
		int              i;
		rst_n = 1'b0;
		ir = '0;
		ir_valid = 1'b0;
		bc = 1'b0;
		cur_kind = K_ADD;
		rng = 32'h4a2a_4af4;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		for (i = 0; i < N_INSTR; i++) begin
			k = instr_kind_e'(i % 8);
			rng = lcg_next(rng);
			b = rng[31];
			case (k)
				K_ADD: op = {4'b0011, rng[27:24], rng[23:20], 4'b1100};
				K_CMPEQ: op = {4'b0011, rng[27:24], rng[23:20], 4'b0000};
				K_LOAD: op = {4'b0101, rng[27:24], rng[23:20], rng[19:16]};	// Disp group
				K_STORE: op = {4'b0010, rng[27:24], rng[23:20], 4'b0000};
				K_BRA: op = {4'b1010, rng[27:16]};
				K_BSR: op = {4'b1011, rng[27:16]};
				K_BT: begin
					op = {8'h89, rng[23:16]};
					b = ((i / 8) % 2) == 1;	// Both outcomes
				end
				default: begin
					case (rng[25:24])
						2'd0: op = {4'b0000, rng[27:24], rng[23:20], 4'b1111};	// MAC.L
						2'd1: op = {8'hc3, rng[23:16]};	// TRAPA
						default: op = {4'b0100, rng[27:24], 8'h0e};	// LDC Rm,SR
					endcase
				end
			endcase
			drive_instr(k, op, b);
			if (rng[30]) begin
				ir_valid <= 1'b0;
				@(posedge clk);
			end
		end
		ir_valid <= 1'b0;
		repeat (3) @(posedge clk);
		$display("Result: PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("Watchdog expired before the instruction sequence finished");
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
hdl/sh_decode_pkg.sv
hdl/sh_arith_decoder.sv
hdl/sh_move_decoder.sv
hdl/sh_branch_decoder.sv
hdl/sh_step_sequencer.sv
hdl/sh_decode_select.sv
hdl/sh_decode_unit.sv
dv/tb_sh_decode_unit.sv

/* hdl/sh_arith_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sh_decode_params.svh"

module sh_arith_decoder import sh_decode_pkg::*; (
	input  logic [`SH_IR_W-1:0]   ir,
	input  logic [`SH_STEP_W-1:0] step,
	output dec_result_t           res
);

	logic [`SH_REGN_W-1:0] ran;
	logic [`SH_REGN_W-1:0] rbn;
	logic                  hit;
	dec_instr_t            d;

	assign ran = {1'b0, ir[11:8]};
	assign rbn = {1'b0, ir[7:4]};

	always_comb begin
		hit = 1'b1;
		d = DECI_RESET;
		case (ir[15:12])
			4'b0000: begin
				case (ir[3:0])
					4'b1000: begin	// CLRT, SETT
						hit = (ir[11:5] == 7'd0);
						d.dp.rsc = 1'b1;
						d.immt = ir[4] ? IMM_ONE : IMM_ZERO;
						d.alu = alu_ctl(1'b0, 1'b1, ALU_NOP, 4'b0000, 3'b000);
						d.tw = 1'b1;
					end
					4'b1001: begin
						case (ir[7:4])
							4'b0000: ;	// NOP
							4'b0010: begin	// MOVT Rn
								d.ra = reg_port(ran, 1'b0, 1'b1);
								d.dp = '{rsb: SRC_B_SR, rsc: 1'b1, pcm: 1'b0};
								d.immt = IMM_ONE;
								d.alu = alu_ctl(1'b0, 1'b1, ALU_LOG, 4'b0000, 3'b000);
							end
							default: hit = 1'b0;
						endcase
					end
					default: hit = 1'b0;
				endcase
			end
			4'b0010: begin
				d.ra = reg_port(ran, 1'b1, 1'b1);
				d.rb = reg_port(rbn, 1'b1, 1'b0);
				case (ir[3:0])
					4'b1000: begin	// TST
						d.ra.we = 1'b0;
						d.alu = alu_ctl(1'b0, 1'b0, ALU_LOG, 4'b0000, 3'b000);
						d.tw = 1'b1;
					end
					4'b1001: d.alu = alu_ctl(1'b0, 1'b0, ALU_LOG, 4'b0000, 3'b000);	// AND
					4'b1010: d.alu = alu_ctl(1'b0, 1'b0, ALU_LOG, 4'b0010, 3'b000);	// XOR
					4'b1011: d.alu = alu_ctl(1'b0, 1'b0, ALU_LOG, 4'b0100, 3'b000);	// OR
					4'b1100: begin	// CMP/STR
						d.ra.we = 1'b0;
						d.alu = alu_ctl(1'b0, 1'b0, ALU_LOG, 4'b0010, 3'b000);
						d.tw = 1'b1;
					end
					4'b1101: d.alu = alu_ctl(1'b0, 1'b0, ALU_EXT, 4'b0010, 3'b000);	// XTRCT
					default: hit = 1'b0;
				endcase
			end
			4'b0011: begin
				d.ra = reg_port(ran, 1'b1, 1'b0);
				d.rb = reg_port(rbn, 1'b1, 1'b0);
				case (ir[3:0])
					4'b0000, 4'b0010, 4'b0011, 4'b0110, 4'b0111: begin	// CMP/xx Rm,Rn
						d.alu = alu_ctl(1'b0, 1'b0, ALU_ADD, 4'b0101, ir[2:0]);
						d.tw = 1'b1;
					end
					4'b1000, 4'b1010, 4'b1011,	// SUB, SUBC, SUBV
					4'b1100, 4'b1110, 4'b1111: begin	// ADD, ADDC, ADDV
						d.ra.we = 1'b1;
						d.alu = alu_ctl(1'b0, 1'b0, ALU_ADD,
							{ir[1:0], ir[1] & ~ir[0], ~ir[2]}, 3'b000);
						d.tw = |ir[1:0];
					end
					default: hit = 1'b0;
				endcase
			end
			4'b0100: begin
				d.ra = reg_port(ran, 1'b1, 1'b1);
				case (ir[7:0])
					8'h00, 8'h01, 8'h04, 8'h05, 8'h20, 8'h21, 8'h24, 8'h25: begin
						d.alu = alu_ctl(1'b0, 1'b0, ALU_SHIFT,
							{1'b0, ir[2], ir[5], ir[0]}, 3'b000);
						d.tw = 1'b1;	// Shifted-out bit
					end
					8'h08, 8'h09, 8'h18, 8'h19, 8'h28, 8'h29:	// SHLL/SHLR by 2, 8, 16
						d.alu = alu_ctl(1'b0, 1'b0, ALU_SHIFT,
							{1'b1, ir[5], ir[4], ir[0]}, 3'b000);
					8'h10: begin	// DT
						d.dp.rsc = 1'b1;
						d.immt = IMM_ONE;
						d.alu = alu_ctl(1'b0, 1'b1, ALU_ADD, 4'b0101, 3'b000);
						d.tw = 1'b1;
					end
					8'h11, 8'h15: begin	// CMP/PZ, CMP/PL
						d.ra.we = 1'b0;
						d.dp.rsc = 1'b1;
						d.alu = alu_ctl(1'b0, 1'b1, ALU_ADD, 4'b0101, {ir[2], 2'b11});
						d.tw = 1'b1;
					end
					default: hit = 1'b0;
				endcase
			end
			4'b0110: begin
				d.ra = reg_port(ran, 1'b0, 1'b1);
				d.rb = reg_port(rbn, 1'b1, 1'b0);
				case (ir[3:0])
					4'b0111: begin	// NOT
						d.dp.rsc = 1'b1;
						d.alu = alu_ctl(1'b1, 1'b0, ALU_LOG, 4'b0101, 3'b000);
					end
					4'b1000, 4'b1001,	// SWAP
					4'b1100, 4'b1101, 4'b1110, 4'b1111:	// EXTU, EXTS
						d.alu = alu_ctl(1'b0, 1'b0, ALU_EXT, {1'b0, ir[2:0]}, 3'b000);
					4'b1010, 4'b1011: begin	// NEGC, NEG
						d.dp.rsc = 1'b1;
						d.alu = alu_ctl(1'b1, 1'b0, ALU_ADD,
							{~ir[0], 1'b0, ~ir[0], 1'b1}, 3'b000);
						d.tw = ~ir[0];
					end
					default: hit = 1'b0;
				endcase
			end
			4'b0111: begin	// ADD #imm,Rn
				d.ra = reg_port(ran, 1'b1, 1'b1);
				d.dp.rsc = 1'b1;
				d.immt = IMM_SIMM8;
				d.alu = alu_ctl(1'b0, 1'b1, ALU_ADD, 4'b0000, 3'b000);
			end
			4'b1000: begin	// CMP/EQ #imm,R0
				hit = (ir[11:8] == 4'b1000);
				d.ra = reg_port(`SH_REG_R0, 1'b1, 1'b0);
				d.dp.rsc = 1'b1;
				d.immt = IMM_SIMM8;
				d.alu = alu_ctl(1'b0, 1'b1, ALU_ADD, 4'b0101, 3'b000);
				d.tw = 1'b1;
			end
			4'b1100: begin	// TST, AND, XOR, OR #imm,R0
				hit = (ir[11:10] == 2'b10);
				d.ra = reg_port(`SH_REG_R0, 1'b1, |ir[9:8]);
				d.dp.rsc = 1'b1;
				d.immt = IMM_ZIMM8;
				d.alu = alu_ctl(1'b0, 1'b1, ALU_LOG,
					{1'b0, ir[9] & ir[8], ir[9] & ~ir[8], 1'b0}, 3'b000);
				d.tw = ~|ir[9:8];
			end
			4'b1110: begin	// MOV #imm,Rn
				d.ra = reg_port(ran, 1'b0, 1'b1);
				d.dp.rsc = 1'b1;
				d.immt = IMM_SIMM8;
				d.alu = alu_ctl(1'b0, 1'b1, ALU_NOP, 4'b0000, 3'b000);
			end
			default: hit = 1'b0;
		endcase
		if (step != '0) begin
			d = DECI_RESET;	// Single step group
		end
	end

	assign res = '{hit: hit, deci: d};

endmodule

`default_nettype wire

/* hdl/sh_branch_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sh_decode_params.svh"

module sh_branch_decoder import sh_decode_pkg::*; (
	input  logic [`SH_IR_W-1:0]   ir,
	input  logic [`SH_STEP_W-1:0] step,
	input  logic                  bc,
	output dec_result_t           res
);

	localparam logic [`SH_STEP_W-1:0] STEP_ONE = {{(`SH_STEP_W-1){1'b0}}, 1'b1};

	logic [`SH_REGN_W-1:0] ran;
	logic                  hit;
	dec_instr_t            d;

	assign ran = {1'b0, ir[11:8]};

	always_comb begin
		hit = 1'b1;
		d = DECI_RESET;
		d.lst = STEP_ONE;
		d.pcw = 1'b1;
		d.dp.rsb = SRC_B_PC;
		d.br = '{bi: 1'b1, bt: BR_UCB, bcv: 1'b0, bsr: 1'b0};
		case (ir[15:12])
			4'b0000: begin
				if (ir[11:0] == 12'h00b) begin	// RTS
					d.rb = reg_port(`SH_REG_PR, 1'b1, 1'b0);
					d.dp.rsb = SRC_B_REG;
				end else begin	// BSRF, BRAF
					hit = (ir[3:0] == 4'b0011) && (ir[7:6] == 2'b00) && !ir[4];
					d.ra = reg_port(ran, 1'b1, 1'b0);
					d.rb = reg_port(`SH_REG_PR, 1'b0, ~ir[5]);
					d.alu = alu_ctl(1'b0, 1'b0, ALU_ADD, 4'b0000, 3'b000);
					d.br.bsr = ~ir[5];
				end
			end
			4'b0100: begin	// JSR, JMP
				hit = (ir[3:0] == 4'b1011) && (ir[7:4] == 4'b0000 || ir[7:4] == 4'b0010);
				d.ra = reg_port(ran, 1'b1, 1'b0);
				d.rb = reg_port(`SH_REG_PR, 1'b0, ~ir[5]);
				d.dp.rsc = 1'b1;
				d.alu = alu_ctl(1'b0, 1'b1, ALU_ADD, 4'b0000, 3'b000);
				d.br.bsr = ~ir[5];
			end
			4'b1000: begin	// BT, BF, BT/S, BF/S
				hit = ir[11] && ir[8];
				d.dp.rsc = 1'b1;
				d.immt = IMM_SIMM8;
				d.alu = alu_ctl(1'b1, 1'b0, ALU_ADD, 4'b0000, 3'b000);
				d.pcw = bc;
				d.br = '{bi: 1'b1, bt: ir[10] ? BR_DCB : BR_CB, bcv: ~ir[9], bsr: 1'b0};
				d.lst = {{(`SH_STEP_W-1){1'b0}}, bc};	// Not taken ends now
			end
			4'b1010, 4'b1011: begin	// BRA, BSR
				d.rb = reg_port(`SH_REG_PR, 1'b0, ir[12]);
				d.dp.rsc = 1'b1;
				d.immt = IMM_SIMM12;
				d.alu = alu_ctl(1'b1, 1'b0, ALU_ADD, 4'b0000, 3'b000);
				d.br.bsr = ir[12];
			end
			default: hit = 1'b0;
		endcase
		if (step != '0) begin
			d = DECI_RESET;	// Idle slot
			d.lst = STEP_ONE;
		end
	end

	assign res = '{hit: hit, deci: d};

endmodule

`default_nettype wire

/* hdl/sh_decode_pkg.sv */
`default_nettype none

`include "sh_decode_params.svh"

package sh_decode_pkg;

	typedef struct packed {
		logic [`SH_REGN_W-1:0] num;
		logic                  re;
		logic                  we;
	} reg_port_t;

	typedef enum logic [2:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_LOG,
		ALU_EXT,
		ALU_SHIFT
	} alu_op_e;

	typedef struct packed {
		logic       sa;	// A from immediate path
		logic       sb;	// B from immediate path
		alu_op_e    op;
		logic [3:0] cd;
		logic [2:0] cmp;
	} alu_ctl_t;

	typedef enum logic [2:0] {
		IMM_ZERO,
		IMM_ONE,
		IMM_ZIMM4,
		IMM_ZIMM8,
		IMM_SIMM8,
		IMM_SIMM12
	} imm_type_e;

	typedef enum logic [1:0] {
		SRC_B_REG,
		SRC_B_PC,
		SRC_B_SR
	} src_b_e;

	typedef struct packed {
		src_b_e rsb;
		logic   rsc;	// C from immediate
		logic   pcm;	// Long PC-relative alignment
	} dp_ctl_t;

	typedef enum logic [1:0] {
		MEM_ALU_RES,
		MEM_ALU_A,
		MEM_ALU_B
	} mem_src_e;

	typedef struct packed {
		mem_src_e   adds;
		mem_src_e   wds;
		logic [1:0] sz;
		logic       r;
		logic       w;
	} mem_ctl_t;

	typedef enum logic [1:0] {
		BR_UCB,
		BR_CB,
		BR_DCB
	} br_type_e;

	typedef struct packed {
		logic     bi;
		br_type_e bt;
		logic     bcv;	// T value that takes the branch
		logic     bsr;
	} br_ctl_t;

	typedef struct packed {
		reg_port_t             ra;
		reg_port_t             rb;
		logic                  r0r;
		dp_ctl_t               dp;
		imm_type_e             immt;
		alu_ctl_t              alu;
		mem_ctl_t              mem;
		logic                  pcw;
		br_ctl_t               br;
		logic                  tw;	// T bit update
		logic [`SH_STEP_W-1:0] lst;
	} dec_instr_t;

	typedef struct packed {
		logic       hit;
		dec_instr_t deci;
	} dec_result_t;

	localparam dec_instr_t DECI_RESET = '{
		ra:   '{num: '0, re: 1'b0, we: 1'b0},
		rb:   '{num: '0, re: 1'b0, we: 1'b0},
		r0r:  1'b0,
		dp:   '{rsb: SRC_B_REG, rsc: 1'b0, pcm: 1'b0},
		immt: IMM_ZERO,
		alu:  '{sa: 1'b0, sb: 1'b0, op: ALU_NOP, cd: 4'b0000, cmp: 3'b000},
		mem:  '{adds: MEM_ALU_RES, wds: MEM_ALU_RES, sz: 2'b00, r: 1'b0, w: 1'b0},
		pcw:  1'b0,
		br:   '{bi: 1'b0, bt: BR_UCB, bcv: 1'b0, bsr: 1'b0},
		tw:   1'b0,
		lst:  '0
	};

	function automatic reg_port_t reg_port(
		input logic [`SH_REGN_W-1:0] num,
		input logic                  re,
		input logic                  we
	);
		return '{num: num, re: re, we: we};
	endfunction

	function automatic alu_ctl_t alu_ctl(
		input logic       sa,
		input logic       sb,
		input alu_op_e    op,
		input logic [3:0] cd,
		input logic [2:0] cmp
	);
		return '{sa: sa, sb: sb, op: op, cd: cd, cmp: cmp};
	endfunction

	function automatic mem_ctl_t mem_ctl(
		input mem_src_e   adds,
		input mem_src_e   wds,
		input logic [1:0] sz,
		input logic       r,
		input logic       w
	);
		return '{adds: adds, wds: wds, sz: sz, r: r, w: w};
	endfunction

endpackage

`default_nettype wire

/* hdl/sh_decode_select.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sh_decode_params.svh"

module sh_decode_select import sh_decode_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ir_valid,
	input  dec_result_t           arith_res,
	input  dec_result_t           move_res,
	input  dec_result_t           branch_res,
	output logic [`SH_STEP_W-1:0] last_step,
	output dec_instr_t            deci,
	output logic                  deci_valid,
	output logic                  illegal
);

	dec_instr_t sel;
	logic       any_hit;

	// Groups never overlap
	always_comb begin
		any_hit = 1'b1;
		if (arith_res.hit) begin
			sel = arith_res.deci;
		end else if (move_res.hit) begin
			sel = move_res.deci;
		end else if (branch_res.hit) begin
			sel = branch_res.deci;
		end else begin
			sel = DECI_RESET;	// Ends in step 0
			any_hit = 1'b0;
		end
	end

	assign last_step = sel.lst;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			deci <= DECI_RESET;
			deci_valid <= 1'b0;
			illegal <= 1'b0;
		end else begin
			deci <= ir_valid ? sel : DECI_RESET;
			deci_valid <= ir_valid;
			illegal <= ir_valid && !any_hit;
		end
	end

endmodule

`default_nettype wire

/* hdl/sh_decode_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sh_decode_params.svh"

module sh_decode_unit import sh_decode_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`SH_IR_W-1:0]   ir,
	input  logic                  ir_valid,
	input  logic                  bc,
	output dec_instr_t            deci,
	output logic                  deci_valid,
	output logic                  illegal,
	output logic [`SH_STEP_W-1:0] step,
	output logic                  ir_done
);

	dec_result_t           arith_res;
	dec_result_t           move_res;
	dec_result_t           branch_res;
	logic [`SH_STEP_W-1:0] last_step;

	sh_step_sequencer sh_step_sequencer_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ir_valid  (ir_valid),
		.last_step (last_step),
		.step      (step),
		.ir_done   (ir_done)
	);

	sh_arith_decoder sh_arith_decoder_i (
		.ir   (ir),
		.step (step),
		.res  (arith_res)
	);

	sh_move_decoder sh_move_decoder_i (
		.ir   (ir),
		.step (step),
		.res  (move_res)
	);

	sh_branch_decoder sh_branch_decoder_i (
		.ir   (ir),
		.step (step),
		.bc   (bc),
		.res  (branch_res)
	);

	sh_decode_select sh_decode_select_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.ir_valid   (ir_valid),
		.arith_res  (arith_res),
		.move_res   (move_res),
		.branch_res (branch_res),
		.last_step  (last_step),
		.deci       (deci),
		.deci_valid (deci_valid),
		.illegal    (illegal)
	);

endmodule

`default_nettype wire

/* hdl/sh_move_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sh_decode_params.svh"

module sh_move_decoder import sh_decode_pkg::*; (
	input  logic [`SH_IR_W-1:0]   ir,
	input  logic [`SH_STEP_W-1:0] step,
	output dec_result_t           res
);

	logic [`SH_REGN_W-1:0] ran;
	logic [`SH_REGN_W-1:0] rbn;
	logic                  hit;
	dec_instr_t            d;

	assign ran = {1'b0, ir[11:8]};
	assign rbn = {1'b0, ir[7:4]};

	always_comb begin
		hit = 1'b1;
		d = DECI_RESET;
		case (ir[15:12])
			4'b0000: begin
				d.rb = reg_port(rbn, 1'b1, 1'b0);
				case (ir[3:0])
					4'b0100, 4'b0101, 4'b0110: begin	// MOV.x Rm,@(R0,Rn)
						d.ra = reg_port(ran, 1'b1, 1'b0);
						d.r0r = 1'b1;
						d.alu = alu_ctl(1'b0, 1'b1, ALU_ADD, 4'b0000, 3'b000);
						d.mem = mem_ctl(MEM_ALU_RES, MEM_ALU_B, ir[1:0], 1'b0, 1'b1);
					end
					4'b1100, 4'b1101, 4'b1110: begin	// MOV.x @(R0,Rm),Rn
						d.ra = reg_port(ran, 1'b0, 1'b1);
						d.r0r = 1'b1;
						d.alu = alu_ctl(1'b1, 1'b0, ALU_ADD, 4'b0000, 3'b000);
						d.mem = mem_ctl(MEM_ALU_RES, MEM_ALU_B, ir[1:0], 1'b1, 1'b0);
					end
					4'b1010: begin	// STS PR,Rn
						hit = (ir[7:4] == 4'b0010);
						d.ra = reg_port(ran, 1'b0, 1'b1);
						d.rb = reg_port(`SH_REG_PR, 1'b1, 1'b0);
					end
					default: hit = 1'b0;
				endcase
			end
			4'b0001, 4'b0010: begin	// Stores through Rn
				hit = ir[12] || (!ir[3] && ir[1:0] != 2'b11);
				d.ra = reg_port(ran, 1'b1, !ir[12] && ir[2]);	// Pre-decrement writes back
				d.rb = reg_port(rbn, 1'b1, 1'b0);
				d.dp.rsc = 1'b1;
				d.immt = ir[12] ? IMM_ZIMM4 : (ir[2] ? IMM_ONE : IMM_ZERO);
				d.alu = alu_ctl(1'b0, 1'b1, ALU_ADD, {3'b000, !ir[12] && ir[2]}, 3'b000);
				d.mem = mem_ctl(MEM_ALU_RES, MEM_ALU_B, ir[12] ? 2'b10 : ir[1:0], 1'b0, 1'b1);
			end
			4'b0100: begin
				d.dp.rsc = 1'b1;
				d.immt = IMM_ONE;
				case (ir[7:0])
					8'h22: begin	// STS.L PR,@-Rn
						d.ra = reg_port(ran, 1'b1, 1'b1);
						d.rb = reg_port(`SH_REG_PR, 1'b1, 1'b0);
						d.alu = alu_ctl(1'b0, 1'b1, ALU_ADD, 4'b0001, 3'b000);
						d.mem = mem_ctl(MEM_ALU_RES, MEM_ALU_B, 2'b10, 1'b0, 1'b1);
					end
					8'h26: begin	// LDS.L @Rm+,PR
						d.ra = reg_port(`SH_REG_PR, 1'b0, 1'b1);
						d.rb = reg_port(ran, 1'b1, 1'b1);
						d.alu = alu_ctl(1'b1, 1'b0, ALU_ADD, 4'b0000, 3'b000);
						d.mem = mem_ctl(MEM_ALU_B, MEM_ALU_B, 2'b10, 1'b1, 1'b0);
					end
					8'h2a: begin	// LDS Rm,PR
						d.ra = reg_port(ran, 1'b1, 1'b0);
						d.rb = reg_port(`SH_REG_PR, 1'b0, 1'b1);
						d.immt = IMM_ZERO;
						d.alu = alu_ctl(1'b0, 1'b1, ALU_ADD, 4'b0000, 3'b000);
					end
					default: hit = 1'b0;
				endcase
			end
			4'b0101, 4'b0110: begin	// Loads through Rm, MOV Rm,Rn
				hit = ir[12] || (!ir[3] && ir[1:0] != 2'b11) || ir[3:0] == 4'b0011;
				d.ra = reg_port(ran, 1'b0, 1'b1);
				d.rb = reg_port(rbn, 1'b1, !ir[12] && ir[2]);	// Post-increment writes back
				d.dp.rsc = 1'b1;
				d.immt = ir[12] ? IMM_ZIMM4 : (ir[2] ? IMM_ONE : IMM_ZERO);
				d.alu = alu_ctl(1'b1, 1'b0, ALU_ADD, 4'b0000, 3'b000);
				d.mem = mem_ctl((!ir[12] && ir[2]) ? MEM_ALU_B : MEM_ALU_RES, MEM_ALU_B,
					ir[12] ? 2'b10 : ir[1:0], ir[12] || ir[1:0] != 2'b11, 1'b0);
			end
			4'b1000: begin	// MOV.B/W R0 with displacement
				hit = (ir[11] == 1'b0) && (ir[9] == 1'b0);
				d.ra = reg_port(`SH_REG_R0, !ir[10], ir[10]);
				d.rb = reg_port(rbn, 1'b1, 1'b0);
				d.dp.rsc = 1'b1;
				d.immt = IMM_ZIMM4;
				d.alu = alu_ctl(1'b1, 1'b0, ALU_ADD, 4'b0000, 3'b000);
				d.mem = mem_ctl(MEM_ALU_RES, MEM_ALU_A, ir[9:8], ir[10], !ir[10]);
			end
			4'b1001, 4'b1101, 4'b1100: begin	// PC-relative loads, MOVA
				hit = (ir[15:12] != 4'b1100) || (ir[11:8] == 4'b0111);
				d.ra = reg_port(ir[14] && !ir[12] ? `SH_REG_R0 : ran, 1'b0, 1'b1);
				d.dp = '{rsb: SRC_B_PC, rsc: 1'b1, pcm: ir[14]};
				d.immt = IMM_ZIMM8;
				d.alu = alu_ctl(1'b1, 1'b0, ALU_ADD, 4'b0000, 3'b000);
				d.mem = mem_ctl(MEM_ALU_RES, MEM_ALU_A, {ir[14], ~ir[14]}, ir[12], 1'b0);
			end
			default: hit = 1'b0;
		endcase
		if (step != '0) begin
			d = DECI_RESET;	// Single step group
		end
	end

	assign res = '{hit: hit, deci: d};

endmodule

`default_nettype wire

/* hdl/sh_step_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sh_decode_params.svh"

module sh_step_sequencer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ir_valid,
	input  logic [`SH_STEP_W-1:0] last_step,
	output logic [`SH_STEP_W-1:0] step,
	output logic                  ir_done
);

	assign ir_done = ir_valid && (step == last_step);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step <= '0;
		end else if (!ir_valid || ir_done) begin
			step <= '0;	// Ready for next instruction
		end else begin
			step <= step + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* include/sh_decode_params.svh */
`ifndef SH_DECODE_PARAMS_SVH
`define SH_DECODE_PARAMS_SVH

// Opcode width
`define SH_IR_W    16

// Register number, bit 4 selects PR
`define SH_REGN_W  5

// Execution step counter width
`define SH_STEP_W  3

// Fixed register numbers
`define SH_REG_R0  5'd0
`define SH_REG_PR  5'd16

`endif
